// ==== cdc_credit_fifo.f ====
logic/cdc_fifo_pkg.sv
logic/dual_port_ram.sv
logic/wr_ptr_ctrl.sv
logic/rd_ptr_ctrl.sv
logic/credit_issuer.sv
logic/cdc_credit_fifo.sv
tests/cdc_credit_fifo_assertions.sv
tests/cdc_credit_fifo_tb.sv

// ==== logic/cdc_credit_fifo.sv ====
`timescale 1ns/10ps

module cdc_credit_fifo #(
  parameter int DATA_WIDTH  = cdc_fifo_pkg::def_data_width,
  parameter int FIFO_DEPTH  = cdc_fifo_pkg::def_fifo_depth,
  parameter int FIFO_AFULL  = cdc_fifo_pkg::def_fifo_afull,
  parameter int FIFO_AEMPTY = cdc_fifo_pkg::def_fifo_aempty
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_valid,
  input  logic [DATA_WIDTH-1:0] wr_data,
  output logic                  credit_return,
  output logic                  full,
  output logic                  afull,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  rd_valid,
  output logic                  empty,
  output logic                  aempty
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  logic                  we;
  logic [ADDR_WIDTH-1:0] waddr;
  logic                  re;
  logic [ADDR_WIDTH-1:0] raddr;
  logic [ADDR_WIDTH:0]   wr_gray;
  logic [ADDR_WIDTH:0]   rd_gray;
  logic [ADDR_WIDTH:0]   rd_ptr_sync;

  dual_port_ram #(
    .DATA_WIDTH (DATA_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_ram (
    .wr_clk (wr_clk),
    .we     (we),
    .waddr  (waddr),
    .wdata  (wr_data),
    .rd_clk (rd_clk),
    .re     (re),
    .raddr  (raddr),
    .rdata  (rd_data)
  );

  wr_ptr_ctrl #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .FIFO_AFULL (FIFO_AFULL)
  ) u_wr_ptr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_valid    (wr_valid),
    .rd_gray     (rd_gray),
    .we          (we),
    .waddr       (waddr),
    .wr_gray     (wr_gray),
    .rd_ptr_sync (rd_ptr_sync),
    .full        (full),
    .afull       (afull)
  );

  rd_ptr_ctrl #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) u_rd_ptr_ctrl (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .wr_gray  (wr_gray),
    .re       (re),
    .raddr    (raddr),
    .rd_gray  (rd_gray),
    .rd_valid (rd_valid),
    .empty    (empty),
    .aempty   (aempty)
  );

  // credits follow the read pointer as the write side sees it
  credit_issuer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_credit_issuer (
    .wr_clk        (wr_clk),
    .wr_rst_n      (wr_rst_n),
    .rd_ptr_sync   (rd_ptr_sync),
    .credit_return (credit_return)
  );

endmodule

// ==== logic/cdc_fifo_pkg.sv ====
package cdc_fifo_pkg;

  // default word width of the FIFO payload
  parameter int def_data_width = 8;

  // depth must stay a power of two for the gray pointer scheme
  parameter int def_fifo_depth = 16;

  // almost flag thresholds, in words
  parameter int def_fifo_afull  = 12;
  parameter int def_fifo_aempty = 2;

  // occupancy levels and credit counts, good for depths up to 128
  typedef logic [7:0] level_t;

endpackage

// ==== logic/credit_issuer.sv ====
`timescale 1ns/10ps

module credit_issuer #(
  parameter int FIFO_DEPTH = cdc_fifo_pkg::def_fifo_depth,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH)
) (
  input  logic                wr_clk,
  input  logic                wr_rst_n,
  input  logic [ADDR_WIDTH:0] rd_ptr_sync,
  output logic                credit_return
);

  import cdc_fifo_pkg::*;

  logic [ADDR_WIDTH:0] last_rd_ptr;
  logic [ADDR_WIDTH:0] advance;
  level_t              advance_lvl;
  level_t              pending;
  level_t              pending_nxt;

  // slots freed since the last look at the read pointer
  assign advance     = rd_ptr_sync - last_rd_ptr;
  assign advance_lvl = level_t'(advance);

  // one credit per cycle while anything is owed
  assign credit_return = (pending != '0);

  always_comb begin
    pending_nxt = pending + advance_lvl;
    if (credit_return) begin
      pending_nxt = pending_nxt - level_t'(1);
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      last_rd_ptr <= '0;
      pending     <= '0;
    end else begin
      last_rd_ptr <= rd_ptr_sync;
      pending     <= pending_nxt;
    end
  end

endmodule

// ==== logic/dual_port_ram.sv ====
`timescale 1ns/10ps

module dual_port_ram #(
  parameter int DATA_WIDTH = cdc_fifo_pkg::def_data_width,
  parameter int FIFO_DEPTH = cdc_fifo_pkg::def_fifo_depth,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH)
) (
  input  logic                  wr_clk,
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic                  rd_clk,
  input  logic                  re,
  input  logic [ADDR_WIDTH-1:0] raddr,
  output logic [DATA_WIDTH-1:0] rdata
);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read port, one rd_clk of latency
  always_ff @(posedge rd_clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

// ==== logic/rd_ptr_ctrl.sv ====
`timescale 1ns/10ps

module rd_ptr_ctrl #(
  parameter int FIFO_DEPTH  = cdc_fifo_pkg::def_fifo_depth,
  parameter int FIFO_AEMPTY = cdc_fifo_pkg::def_fifo_aempty,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH)
) (
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH:0]   wr_gray,
  output logic                  re,
  output logic [ADDR_WIDTH-1:0] raddr,
  output logic [ADDR_WIDTH:0]   rd_gray,
  output logic                  rd_valid,
  output logic                  empty,
  output logic                  aempty
);

  import cdc_fifo_pkg::*;

  logic [ADDR_WIDTH:0] rd_ptr;
  logic [ADDR_WIDTH:0] rd_ptr_nxt;
  logic [ADDR_WIDTH:0] wr_gray_s1;
  logic [ADDR_WIDTH:0] wr_gray_s2;
  logic [ADDR_WIDTH:0] wr_ptr_sync;
  logic [ADDR_WIDTH:0] ptr_diff;
  level_t              occupancy;

  assign re         = rd_en && !empty;
  assign raddr      = rd_ptr[ADDR_WIDTH-1:0];
  assign rd_ptr_nxt = re ? rd_ptr + 1'b1 : rd_ptr;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr   <= '0;
      rd_gray  <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_ptr   <= rd_ptr_nxt;
      rd_gray  <= (rd_ptr_nxt >> 1) ^ rd_ptr_nxt;
      // data leaves the RAM register one cycle after the accepted read
      rd_valid <= re;
    end
  end

  // write pointer into the read domain
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  always_comb begin
    wr_ptr_sync[ADDR_WIDTH] = wr_gray_s2[ADDR_WIDTH];
    for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
      wr_ptr_sync[i] = wr_ptr_sync[i+1] ^ wr_gray_s2[i];
    end
  end

  // both flags lag writes, so they only ever err towards empty
  assign empty = (rd_ptr == wr_ptr_sync);

  assign ptr_diff  = wr_ptr_sync - rd_ptr;
  assign occupancy = level_t'(ptr_diff);
  assign aempty    = (occupancy <= level_t'(FIFO_AEMPTY));

endmodule

// ==== logic/wr_ptr_ctrl.sv ====
`timescale 1ns/10ps

module wr_ptr_ctrl #(
  parameter int FIFO_DEPTH = cdc_fifo_pkg::def_fifo_depth,
  parameter int FIFO_AFULL = cdc_fifo_pkg::def_fifo_afull,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH)
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_valid,
  input  logic [ADDR_WIDTH:0]   rd_gray,
  output logic                  we,
  output logic [ADDR_WIDTH-1:0] waddr,
  output logic [ADDR_WIDTH:0]   wr_gray,
  output logic [ADDR_WIDTH:0]   rd_ptr_sync,
  output logic                  full,
  output logic                  afull
);

  import cdc_fifo_pkg::*;

  logic [ADDR_WIDTH:0] wr_ptr;
  logic [ADDR_WIDTH:0] wr_ptr_nxt;
  logic [ADDR_WIDTH:0] rd_gray_s1;
  logic [ADDR_WIDTH:0] rd_gray_s2;
  logic [ADDR_WIDTH:0] ptr_diff;
  level_t              occupancy;

  assign we         = wr_valid && !full;
  assign waddr      = wr_ptr[ADDR_WIDTH-1:0];
  assign wr_ptr_nxt = we ? wr_ptr + 1'b1 : wr_ptr;

  // gray code is registered so the crossing sees a clean one-bit change
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr  <= '0;
      wr_gray <= '0;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      wr_gray <= (wr_ptr_nxt >> 1) ^ wr_ptr_nxt;
    end
  end

  // two-flop synchronizer for the read pointer
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  always_comb begin
    rd_ptr_sync[ADDR_WIDTH] = rd_gray_s2[ADDR_WIDTH];
    for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
      rd_ptr_sync[i] = rd_ptr_sync[i+1] ^ rd_gray_s2[i];
    end
  end

  // full when the pointers differ only in the wrap bit
  assign full = (wr_ptr == {~rd_ptr_sync[ADDR_WIDTH], rd_ptr_sync[ADDR_WIDTH-1:0]});

  assign ptr_diff  = wr_ptr - rd_ptr_sync;
  assign occupancy = level_t'(ptr_diff);
  assign afull     = (occupancy >= level_t'(FIFO_AFULL));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f cdc_credit_fifo.f \
  --top-module cdc_credit_fifo_tb -Mdir obj_dir -o sim

status=0
./obj_dir/sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

// ==== tests/cdc_credit_fifo_assertions.sv ====
`timescale 1ns/10ps

module cdc_credit_fifo_assertions (
  input logic wr_clk,
  input logic wr_rst_n,
  input logic wr_valid,
  input logic full,
  input logic credit_return,
  input logic rd_clk,
  input logic rd_rst_n,
  input logic rd_en,
  input logic empty,
  input logic rd_valid
);

  // a sender that keeps to its credits never meets a full FIFO
  no_write_when_full: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) !(wr_valid && full)
  ) else $error("wr_valid high while full");

  read_gives_valid: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) (rd_en && !empty) |=> rd_valid
  ) else $error("rd_valid missing one cycle after an accepted read");

  no_read_no_valid: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) !(rd_en && !empty) |=> !rd_valid
  ) else $error("rd_valid without an accepted read");

  wr_reset_release: assert property (
    @(posedge wr_clk) $rose(wr_rst_n) |-> !full
  ) else $error("full high at write reset release");

  rd_reset_release: assert property (
    @(posedge rd_clk) $rose(rd_rst_n) |-> (empty && !full)
  ) else $error("empty low or full high at read reset release");

  no_credit_in_reset: assert property (
    @(posedge wr_clk) !wr_rst_n |-> !credit_return
  ) else $error("credit_return high during reset");

endmodule

bind cdc_credit_fifo cdc_credit_fifo_assertions u_assertions (
  .wr_clk        (wr_clk),
  .wr_rst_n      (wr_rst_n),
  .wr_valid      (wr_valid),
  .full          (full),
  .credit_return (credit_return),
  .rd_clk        (rd_clk),
  .rd_rst_n      (rd_rst_n),
  .rd_en         (rd_en),
  .empty         (empty),
  .rd_valid      (rd_valid)
);

// ==== tests/cdc_credit_fifo_stim.txt ====
// op count args: 1 = write count data words, 2 = count reads with stall cycles, 3 = settle and
// check level flags, 4 = settle and check full, 5 = read while empty, 6 = drain and check credits
1 08 a5 5a 01 02 04 08 10 20
1 08 40 80 ff 7e c3 3c 96 69
4 00
// credits come back only as the reader frees slots
2 08 00 00 00 01 00 03 00 02
1 08 11 22 33 44 55 66 77 88
2 04 01 00 00 02
3 00
2 0a 00 00 00 00 00 00 00 00 00 00
3 00
2 02 03 00
3 00
5 06
// interleaved bursts from empty
1 06 9a bc de f0 12 34
2 03 00 02 00
1 06 56 78 9b cd ef 0d
2 04 01 00 01 00
3 00
1 04 e1 e2 e3 e4
2 09 00 00 00 00 01 00 00 00 02
3 00
6 00
1 08 c0 c1 c2 c3 c4 c5 c6 c7
2 08 00 00 00 00 00 00 00 00
1 08 d0 d1 d2 d3 d4 d5 d6 d7
2 08 00 00 00 00 00 00 00 00
3 00
6 00
f 00

// ==== tests/cdc_credit_fifo_tb.sv ====
`timescale 1ns/10ps

module cdc_credit_fifo_tb;

  import cdc_fifo_pkg::*;

  localparam int    DATA_WIDTH    = def_data_width;
  localparam int    FIFO_DEPTH    = def_fifo_depth;
  localparam int    FIFO_AFULL    = def_fifo_afull;
  localparam int    FIFO_AEMPTY   = def_fifo_aempty;
  localparam string STIM_FILE     = "tests/cdc_credit_fifo_stim.txt";
  localparam int    SETTLE_CYCLES = 12;
  localparam int    IDLE_TIMEOUT  = 4000;
  localparam int    READ_TIMEOUT  = 500;

  logic                  wr_clk;
  logic                  wr_rst_n;
  logic                  wr_valid;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  credit_return;
  logic                  full;
  logic                  afull;
  logic                  rd_clk;
  logic                  rd_rst_n;
  logic                  rd_en;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  rd_valid;
  logic                  empty;
  logic                  aempty;

  logic [7:0]            stim_mem [256];
  logic [7:0]            stim_idx;
  logic [DATA_WIDTH-1:0] wr_q [$];
  int                    rd_q [$];
  logic [DATA_WIDTH-1:0] scoreboard [$];
  int                    credits;
  int                    wr_count;
  int                    rd_accept_count;
  int                    rd_valid_count;
  bit                    reader_busy;

  cdc_credit_fifo #(
    .DATA_WIDTH  (DATA_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_AFULL  (FIFO_AFULL),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) u_dut (.*);

  initial begin
    wr_clk = 1'b0;
    forever #5 wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #7 rd_clk = ~rd_clk;
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      report_error($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    assert (got == exp) else begin
      report_error($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // sender, spends a credit per write and takes one back per credit_return cycle
  initial begin
    wr_valid = 1'b0;
    wr_data  = '0;
    credits  = FIFO_DEPTH;
    wr_count = 0;
    forever begin
      @(negedge wr_clk);
      wr_valid = 1'b0;
      if (wr_rst_n) begin
        if (credit_return) begin
          credits++;
        end
        assert (credits <= FIFO_DEPTH) else report_error("more credits returned than slots");
        if (wr_q.size() > 0 && credits > 0) begin
          wr_data  = wr_q.pop_front();
          wr_valid = 1'b1;
          credits--;
          wr_count++;
          scoreboard.push_back(wr_data);
        end
        // words not yet read cannot have come back as credits
        assert (credits + wr_count - rd_accept_count <= FIFO_DEPTH) else begin
          report_error("credits returned for slots that still hold data");
        end
      end
    end
  end

  task automatic read_one_word(input int stall);
    int cycles;
    int waited;
    cycles = stall;
    if (stall > 0) begin
      cycles = stall + int'($urandom % 3);
    end
    for (int i = 0; i < cycles; i++) begin
      rd_en = 1'b0;
      @(negedge rd_clk);
    end
    rd_en  = 1'b1;
    waited = 0;
    // empty only moves on rising rd_clk, so this is what the next edge sees
    while (empty) begin
      waited++;
      assert (waited < READ_TIMEOUT) else report_error("timeout waiting for a read to be accepted");
      @(negedge rd_clk);
    end
    rd_accept_count++;
  endtask

  task automatic hold_read_on_empty(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      if (i > 0) begin
        @(negedge rd_clk);
      end
      rd_en = 1'b1;
      check_flag("empty", empty, 1'b1);
      check_flag("rd_valid", rd_valid, 1'b0);
    end
  endtask

  // reader, a negative entry holds rd_en on an empty FIFO
  initial begin
    int rd_entry;
    rd_en           = 1'b0;
    reader_busy     = 1'b0;
    rd_accept_count = 0;
    forever begin
      @(negedge rd_clk);
      if (!rd_rst_n || rd_q.size() == 0) begin
        rd_en = 1'b0;
      end else begin
        reader_busy = 1'b1;
        rd_entry    = rd_q.pop_front();
        if (rd_entry < 0) begin
          hold_read_on_empty(-rd_entry);
        end else begin
          read_one_word(rd_entry);
        end
        reader_busy = 1'b0;
      end
    end
  end

  initial begin
    logic [DATA_WIDTH-1:0] expected;
    rd_valid_count = 0;
    forever begin
      @(negedge rd_clk);
      if (rd_rst_n && rd_valid) begin
        assert (scoreboard.size() > 0) else report_error("rd_valid with no word outstanding");
        expected = scoreboard.pop_front();
        assert (rd_data === expected) else begin
          report_error($sformatf("MISMATCH rd_data: got 0x%0h expected 0x%0h", rd_data, expected));
        end
        rd_valid_count++;
      end
    end
  end

  task automatic fetch_token(output logic [7:0] tok);
    tok      = stim_mem[stim_idx];
    stim_idx = stim_idx + 8'd1;
    assert (stim_idx != 8'd0) else report_error("stimulus runs past the stimulus memory");
  endtask

  task automatic wait_until_idle();
    int waited;
    waited = 0;
    while (wr_q.size() > 0 || rd_q.size() > 0 || reader_busy) begin
      waited++;
      assert (waited < IDLE_TIMEOUT) else report_error("timeout waiting for queued writes and reads");
      @(posedge wr_clk);
    end
  endtask

  task automatic settle();
    wait_until_idle();
    repeat (SETTLE_CYCLES) @(negedge rd_clk);
    @(negedge wr_clk);
  endtask

  task automatic check_level_flags();
    int occupancy;
    occupancy = wr_count - rd_accept_count;
    check_flag("afull", afull, occupancy >= FIFO_AFULL);
    check_flag("aempty", aempty, occupancy <= FIFO_AEMPTY);
    check_flag("full", full, occupancy == FIFO_DEPTH);
    check_flag("empty", empty, occupancy == 0);
  endtask

  task automatic run_empty_probe(input int cycles);
    int held_words;
    int held_valids;
    held_words  = scoreboard.size();
    held_valids = rd_valid_count;
    check_flag("empty", empty, 1'b1);
    rd_q.push_back(-cycles);
    settle();
    check_count("scoreboard size", scoreboard.size(), held_words);
    check_count("rd_valid count", rd_valid_count, held_valids);
  endtask

  task automatic check_credits_home();
    int waited;
    wait_until_idle();
    waited = 0;
    while (scoreboard.size() > 0) begin
      waited++;
      assert (waited < IDLE_TIMEOUT) else report_error("timeout waiting for the FIFO to drain");
      @(posedge wr_clk);
    end
    settle();
    @(posedge wr_clk);
    check_count("credits", credits, FIFO_DEPTH);
    check_count("outstanding words", wr_count - rd_accept_count, 0);
  endtask

  task automatic run_stimulus();
    logic [7:0] op;
    logic [7:0] count;
    logic [7:0] tok;
    bit         running;
    running = 1'b1;
    while (running) begin
      fetch_token(op);
      fetch_token(count);
      case (op)
        8'h01: begin
          for (int i = 0; i < int'(count); i++) begin
            fetch_token(tok);
            wr_q.push_back(DATA_WIDTH'(tok));
          end
        end
        8'h02: begin
          for (int i = 0; i < int'(count); i++) begin
            fetch_token(tok);
            rd_q.push_back(int'(tok));
          end
        end
        8'h03: begin
          settle();
          check_level_flags();
        end
        8'h04: begin
          settle();
          check_level_flags();
          @(posedge wr_clk);
          check_count("credits", credits, 0);
        end
        8'h05: run_empty_probe(int'(count));
        8'h06: check_credits_home();
        8'h0f: running = 1'b0;
        default: report_error($sformatf("unknown stimulus op 0x%0h", op));
      endcase
    end
  endtask

  initial begin
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    stim_idx = 8'd0;
    void'($urandom(32'h49eb));
    $readmemh(STIM_FILE, stim_mem);
    fork
      begin
        repeat (5) @(negedge wr_clk);
        wr_rst_n = 1'b1;
      end
      begin
        repeat (5) @(negedge rd_clk);
        rd_rst_n = 1'b1;
      end
    join
    @(negedge wr_clk);
    check_flag("full", full, 1'b0);
    check_flag("afull", afull, 1'b0);
    check_flag("credit_return", credit_return, 1'b0);
    @(negedge rd_clk);
    check_flag("empty", empty, 1'b1);
    check_flag("aempty", aempty, 1'b1);
    check_flag("rd_valid", rd_valid, 1'b0);
    run_stimulus();
    $display("Regression passed");
    $finish;
  end

endmodule
